// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_rvvi_bridge -f verilog.f -o tb_rvvi_bridge \
   && ./obj_dir/tb_rvvi_bridge | tee /dev/stderr | grep -qx "Done: no errors" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: sim/rvvi_bridge_properties.sv
`timescale 1ns/1ps

module rvvi_bridge_properties (
   input logic                                  rvvi,
   input logic                                  rst_n,
   input logic [31:0]                           x_wb,
   input logic [rvvi_bridge_pkg::num_csr-1:0]   csr_wb,
   input rvvi_bridge_pkg::net_state_t           nets,
   input logic                                  resync,
   input rvvi_bridge_pkg::rvvi_trace_t          trace
);
   import rvvi_bridge_pkg::*;

   a_x_wb_onehot : assert property (@(posedge rvvi) disable iff (!rst_n) $onehot0(x_wb))
      else $error("x_wb has more than one bit set");

   a_nmi_cause : assert property (@(posedge rvvi) disable iff (!rst_n)
      nets.nmi |-> ((nets.nmi_cause == cause_nmi_load) || (nets.nmi_cause == cause_nmi_store)))
      else $error("nmi high with an unknown cause");

   a_irq_mask : assert property (@(posedge rvvi) disable iff (!rst_n)
      (nets.irq & ~irq_track_mask) == 32'd0)
      else $error("irq level outside the tracked lines");

   // First cycle out of reset
   a_reset_clear : assert property (@(posedge rvvi)
      $rose(rst_n) |-> ((nets == '0) && !resync && (x_wb == '0) && (csr_wb == '0) &&
                        !trace.valid))
      else $error("levels not cleared by reset");

endmodule

bind rvvi_bridge_top rvvi_bridge_properties i_properties (
   .rvvi   (rvvi),
   .rst_n  (rst_n),
   .x_wb   (x_wb),
   .csr_wb (csr_wb),
   .nets   (nets),
   .resync (resync),
   .trace  (trace)
);

// File: sim/tb_rvvi_bridge.sv
`timescale 1ns/1ps

module tb_rvvi_bridge;
   import rvvi_bridge_pkg::*;

   // Tests run about 300 cycles, the limit keeps a wide margin
   localparam int test_cycles = 300;
   localparam int cycle_limit = test_cycles * 6 + 200;

   logic                         rvvi;
   logic                         rst_n;
   rvfi_retire_t                 retire;
   csr_port_t [num_csr-1:0]      csr;
   logic [31:0]                  irq;
   rvvi_trace_t                  trace;
   logic [31:0]                  x_wb;
   logic [xlen-1:0]              x_wdata;
   logic [num_csr-1:0][xlen-1:0] csr_value;
   logic [num_csr-1:0]           csr_wb;
   net_state_t                   nets;
   logic                         resync;
   integer                       seed = 9706;
   int                           errors = 0;
   int                           checks = 0;
   int                           tests = 0;
   int                           cycles = 0;

   rvvi_bridge_top i_dut (.*);

   initial rvvi = 1'b0;
   always #2 rvvi = ~rvvi;

   always @(posedge rvvi) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("Timeout: simulation stopped after %0d cycles", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   // Inputs change half a ns after the edge, outputs are stable there too
   task automatic step();
      @(posedge rvvi);
      #0.5;
   endtask

   task automatic clear_inputs();
      retire = '0;
      csr    = '0;
      irq    = '0;
   endtask

   // Plain valid records bring all levels and flags back to 0
   task automatic settle();
      clear_inputs();
      retire.valid = 1'b1;
      repeat (3) step();
      clear_inputs();
   endtask

   task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////
   task automatic reset_and_passthrough();
      int           err0;
      rvfi_retire_t r;
      logic         exp_trap;
      logic [31:0]  exp_wb;
      err0 = errors;
      check_eq("reset trace.valid", 64'(trace.valid), 64'd0);
      check_eq("reset x_wb", 64'(x_wb), 64'd0);
      check_eq("reset csr_wb", 64'(csr_wb), 64'd0);
      check_eq("reset nets", 64'(nets), 64'd0);
      check_eq("reset resync", 64'(resync), 64'd0);
      for (int i = 0; i < num_csr; i++) begin
         check_eq("reset csr_value", 64'(csr_value[i]), 64'd0);
      end
      for (int i = 0; i < 24; i++) begin
         r = '0;
         r.valid = ($random(seed) & 3) != 0;
         r.order = {$random(seed), $random(seed)};
         r.insn = $random(seed);
         r.trap.trap = 1'($random(seed));
         r.trap.exception_cause = (i % 3 == 0) ? exc_instr_bus_fault : 6'($random(seed));
         r.intr = 14'($random(seed));
         r.mode = 2'($random(seed));
         r.ixl = 2'($random(seed));
         r.pc_rdata = $random(seed);
         r.pc_wdata = $random(seed);
         r.rd_addr = (i % 5 == 0) ? 5'd0 : 5'($random(seed));
         r.rd_wdata = $random(seed);
         retire = r;
         // Only a fetch bus fault counts as a trace trap
         exp_trap = r.trap.trap && (r.trap.exception_cause == 6'd48);
         exp_wb = (r.valid && r.rd_addr != 5'd0) ? (32'd1 << r.rd_addr) : 32'd0;
         step();
         check_eq("trace.valid", 64'(trace.valid), 64'(r.valid));
         check_eq("trace.order", trace.order, r.order);
         check_eq("trace.insn", 64'(trace.insn), 64'(r.insn));
         check_eq("trace.trap", 64'(trace.trap), 64'(exp_trap));
         check_eq("trace.intr", 64'({trace.intr, trace.mode, trace.ixl}),
                  64'({r.intr, r.mode, r.ixl}));
         check_eq("trace.pc", {trace.pc_rdata, trace.pc_wdata}, {r.pc_rdata, r.pc_wdata});
         check_eq("x_wb", 64'(x_wb), 64'(exp_wb));
         check_eq("x_wdata", 64'(x_wdata), 64'(r.rd_wdata));
      end
      clear_inputs();
      report_test("reset_and_passthrough", err0);
   endtask

   task automatic csr_merge_flags();
      int                 err0;
      logic [xlen-1:0]    held [num_csr];
      logic [num_csr-1:0] flag;
      logic [xlen-1:0]    merged;
      err0 = errors;
      settle();
      flag = '0;
      for (int i = 0; i < num_csr; i++) begin
         held[i] = '0;
      end
      for (int n = 0; n < 12; n++) begin
         // Every third round keeps the CSR inputs unchanged
         if (n % 3 != 2) begin
            for (int i = 0; i < num_csr; i++) begin
               csr[i].rdata = $random(seed);
               csr[i].wdata = $random(seed);
               csr[i].wmask = $random(seed);
            end
         end
         retire.valid = 1'($random(seed));
         for (int i = 0; i < num_csr; i++) begin
            for (int b = 0; b < xlen; b++) begin
               merged[b] = csr[i].wmask[b] ? csr[i].wdata[b] : csr[i].rdata[b];
            end
            if (merged != held[i]) begin
               flag[i] = 1'b1;
            end else if (retire.valid) begin
               flag[i] = 1'b0;
            end
            held[i] = merged;
         end
         step();
         for (int i = 0; i < num_csr; i++) begin
            check_eq("csr_value", 64'(csr_value[i]), 64'(held[i]));
         end
         check_eq("csr_wb", 64'(csr_wb), 64'(flag));
      end
      // Unchanged inputs with a valid record drop every flag
      retire.valid = 1'b1;
      step();
      check_eq("csr_wb cleared", 64'(csr_wb), 64'd0);
      settle();
      report_test("csr_merge_flags", err0);
   endtask

   task automatic interrupt_levels();
      int err0;
      err0 = errors;
      settle();
      retire.valid = 1'b1;
      retire.intr.intr = 1'b1;
      retire.intr.interrupt = 1'b1;
      retire.intr.cause.irq.idx = 5'd7;
      irq = 32'hffff_ffff;
      step();
      check_eq("irq 7 set", 64'(nets.irq[7]), 64'd1);
      clear_inputs();
      step();
      check_eq("irq 7 held", 64'(nets.irq[7]), 64'd1);
      retire.valid = 1'b1;
      step();
      check_eq("irq 7 cleared", 64'(nets.irq[7]), 64'd0);
      // mip is registered once more inside the bridge
      clear_inputs();
      csr[csr_mip].wdata = 32'h8;
      csr[csr_mip].wmask = 32'h8;
      irq = 32'h8;
      step();
      check_eq("irq 3 first cycle", 64'(nets.irq[3]), 64'd0);
      step();
      check_eq("irq 3 set", 64'(nets.irq[3]), 64'd1);
      settle();
      retire.valid = 1'b1;
      retire.intr.interrupt = 1'b1;
      retire.intr.cause.irq.idx = 5'd5;
      irq = 32'hffff_ffff;
      step();
      check_eq("irq 5 untracked", 64'(nets.irq), 64'd0);
      settle();
      report_test("interrupt_levels", err0);
   endtask

   task automatic nmi_levels();
      int err0;
      err0 = errors;
      settle();
      retire.valid = 1'b1;
      retire.intr.intr = 1'b1;
      retire.intr.interrupt = 1'b1;
      retire.intr.cause.raw = 11'd1024;
      step();
      check_eq("nmi load", 64'({nets.nmi, nets.nmi_cause}), 64'({1'b1, 11'd1024}));
      clear_inputs();
      retire.valid = 1'b1;
      retire.nmip = 2'b11;
      step();
      check_eq("nmi store", 64'({nets.nmi, nets.nmi_cause}), 64'({1'b1, 11'd1025}));
      clear_inputs();
      retire.valid = 1'b1;
      step();
      check_eq("nmi idle", 64'(nets.nmi), 64'd0);
      // Pending NMI without a valid record is ignored
      clear_inputs();
      retire.nmip = 2'b01;
      step();
      check_eq("nmi no record", 64'(nets.nmi), 64'd0);
      settle();
      report_test("nmi_levels", err0);
   endtask

   task automatic fault_halt_resync();
      int err0;
      err0 = errors;
      settle();
      retire.valid = 1'b1;
      retire.trap.trap = 1'b1;
      retire.trap.exception = 1'b1;
      retire.trap.exception_cause = 6'd48;
      step();
      check_eq("bus fault set", 64'(nets.instr_bus_fault), 64'd1);
      clear_inputs();
      retire.valid = 1'b1;
      step();
      check_eq("bus fault cleared", 64'(nets.instr_bus_fault), 64'd0);
      // Halt request sets even without a valid record
      clear_inputs();
      retire.dbg = 3'd3;
      retire.dbg_mode = 1'b1;
      step();
      check_eq("haltreq set", 64'(nets.haltreq), 64'd1);
      clear_inputs();
      step();
      check_eq("haltreq held", 64'(nets.haltreq), 64'd1);
      retire.valid = 1'b1;
      step();
      check_eq("haltreq cleared", 64'(nets.haltreq), 64'd0);
      retire.intr.intr = 1'b1;
      retire.dbg = 3'd3;
      retire.dbg_mode = 1'b1;
      step();
      check_eq("resync halt", 64'(resync), 64'd1);
      clear_inputs();
      retire.valid = 1'b1;
      retire.intr.intr = 1'b1;
      retire.trap.exception_cause = 6'd5;
      step();
      check_eq("resync trap", 64'(resync), 64'd1);
      clear_inputs();
      retire.valid = 1'b1;
      retire.intr.intr = 1'b1;
      step();
      check_eq("resync intr only", 64'(resync), 64'd0);
      settle();
      report_test("fault_halt_resync", err0);
   endtask

   initial begin
      rst_n = 1'b0;
      clear_inputs();
      repeat (10) @(posedge rvvi);
      #0.5;
      rst_n = 1'b1;
      reset_and_passthrough();
      csr_merge_flags();
      interrupt_levels();
      nmi_levels();
      fault_halt_resync();
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// File: verilog.f
verilog/rvvi_bridge_pkg.sv
verilog/retire_capture.sv
verilog/csr_merge.sv
verilog/irq_tracker.sv
verilog/async_event_tracker.sv
verilog/rvvi_bridge_top.sv
sim/rvvi_bridge_properties.sv
sim/tb_rvvi_bridge.sv

// File: verilog/async_event_tracker.sv
`timescale 1ns/1ps

module async_event_tracker (
   input  logic                          rvvi,
   input  logic                          rst_n,
   input  rvvi_bridge_pkg::rvfi_retire_t retire,
   output logic                          nmi,
   output logic [10:0]                   nmi_cause,
   output logic                          instr_bus_fault,
   output logic                          haltreq,
   output logic                          resync
);
   import rvvi_bridge_pkg::*;

   nmi_state_e state_q;
   nmi_state_e state_d;
   logic       halt_cond;
   logic       nmi_intr;
   logic       nmi_hit;
   logic       nmi_store;
   logic       fetch_fault;
   logic       resync_d;

   // Halt request seen while entering debug mode
   assign halt_cond = (retire.dbg == dbg_cause_haltreq) && retire.dbg_mode;

   // Load or store bus error NMI taken as an interrupt
   assign nmi_intr = retire.intr.intr && retire.intr.interrupt &&
                     ((retire.intr.cause.raw == cause_nmi_load) ||
                      (retire.intr.cause.raw == cause_nmi_store));
   assign nmi_hit  = nmi_intr || retire.nmip[0];

   // Taken cause decides first, otherwise the nmip store bit
   assign nmi_store = nmi_intr ? (retire.intr.cause.raw == cause_nmi_store) : retire.nmip[1];

   assign fetch_fault = retire.trap.trap && retire.trap.exception &&
                        (retire.trap.exception_cause == exc_instr_bus_fault);

   // Two exception events in one record
   assign resync_d = retire.valid && retire.intr.intr &&
                     (halt_cond || (retire.trap.exception_cause != 6'd0));

   ////////////////////////////////////////
   // NMI state machine
   ////////////////////////////////////////
   always_comb begin
      state_d = state_q;
      if (retire.valid) begin
         if (nmi_hit) begin
            state_d = nmi_store ? NMI_STORE : NMI_LOAD;
         end else begin
            state_d = NMI_IDLE;
         end
      end
   end

   assign nmi = (state_q != NMI_IDLE);

   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         state_q         <= NMI_IDLE;
         nmi_cause       <= '0;
         instr_bus_fault <= 1'b0;
         haltreq         <= 1'b0;
         resync          <= 1'b0;
      end else begin
         state_q <= state_d;
         // Cause is kept after the level drops
         if (retire.valid && nmi_hit) begin
            nmi_cause <= nmi_store ? cause_nmi_store : cause_nmi_load;
         end
         if (retire.valid) begin
            instr_bus_fault <= fetch_fault;
         end
         // Set on the condition alone, clear needs a retire
         if (halt_cond) begin
            haltreq <= 1'b1;
         end else if (retire.valid) begin
            haltreq <= 1'b0;
         end
         resync <= resync_d;
      end
   end

endmodule

// File: verilog/csr_merge.sv
`timescale 1ns/1ps

module csr_merge (
   input  logic                                        rvvi,
   input  logic                                        rst_n,
   input  rvvi_bridge_pkg::rvfi_retire_t               retire,
   input  rvvi_bridge_pkg::csr_port_t [rvvi_bridge_pkg::num_csr-1:0] csr,
   output logic [rvvi_bridge_pkg::num_csr-1:0][rvvi_bridge_pkg::xlen-1:0] csr_value,
   output logic [rvvi_bridge_pkg::num_csr-1:0]        csr_wb
);
   import rvvi_bridge_pkg::*;

   logic [num_csr-1:0][xlen-1:0] merged;
   logic [num_csr-1:0]           changed;

   ////////////////////////////////////////
   // Masked merge per CSR
   ////////////////////////////////////////
   for (genvar i = 0; i < num_csr; i++) begin : g_csr
      // Written bits from wdata, the rest from rdata
      assign merged[i]  = (csr[i].wdata & csr[i].wmask) | (csr[i].rdata & ~csr[i].wmask);
      assign changed[i] = (merged[i] != csr_value[i]);
   end

   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         csr_value <= '0;
         csr_wb    <= '0;
      end else begin
         csr_value <= merged;
         // Change wins over the clear from a retire
         csr_wb    <= changed | (csr_wb & ~{num_csr{retire.valid}});
      end
   end

endmodule

// File: verilog/irq_tracker.sv
`timescale 1ns/1ps

module irq_tracker (
   input  logic                             rvvi,
   input  logic                             rst_n,
   input  rvvi_bridge_pkg::rvfi_retire_t    retire,
   input  logic [rvvi_bridge_pkg::xlen-1:0] mip,
   input  logic [31:0]                      irq,
   output logic [31:0]                      irq_level
);
   import rvvi_bridge_pkg::*;

   logic [31:0] intr_bit;
   logic [31:0] irq_next;
   logic [31:0] irq_clr;

   // Taken interrupt flags its line before mip shows it
   always_comb begin
      intr_bit = '0;
      if (retire.valid && retire.intr.interrupt) begin
         intr_bit[retire.intr.cause.irq.idx] = 1'b1;
      end
   end

   assign irq_next = (mip | intr_bit) & irq_track_mask;

   // Drop only on a retire, once the line or its next value is gone
   assign irq_clr = {32{retire.valid}} & (~irq_next | ~irq);

   ////////////////////////////////////////
   // Level per tracked line
   ////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (!rst_n) begin
         irq_level <= '0;
      end else begin
         // Low bits follow next up, high bits fall on clear
         irq_level <= (irq_level & ~irq_clr) | (~irq_level & irq_next);
      end
   end

endmodule

// File: verilog/retire_capture.sv
`timescale 1ns/1ps

module retire_capture (
   input  logic                            rvvi,
   input  logic                            rst_n,
   input  rvvi_bridge_pkg::rvfi_retire_t   retire,
   output rvvi_bridge_pkg::rvvi_trace_t    trace,
   output logic [31:0]                     x_wb,
   output logic [rvvi_bridge_pkg::xlen-1:0] x_wdata
);
   import rvvi_bridge_pkg::*;

   logic        bus_fault;
   logic [31:0] wb_d;

   // Fetch bus fault comes from outside the core
   // so it is the only trap passed on
   assign bus_fault = retire.trap.trap && (retire.trap.exception_cause == exc_instr_bus_fault);

   // One-hot GPR write-back, x0 excluded
   always_comb begin
      wb_d = '0;
      if (retire.valid && (retire.rd_addr != 5'd0)) begin
         wb_d[retire.rd_addr] = 1'b1;
      end
   end

   always_ff @(posedge rvvi) begin
      // Instruction fields
      trace.order    <= retire.order;
      trace.insn     <= retire.insn;
      trace.trap     <= bus_fault;
      trace.intr     <= retire.intr;
      trace.mode     <= retire.mode;
      trace.ixl      <= retire.ixl;
      trace.pc_rdata <= retire.pc_rdata;
      trace.pc_wdata <= retire.pc_wdata;
      x_wdata        <= retire.rd_wdata;

      if (!rst_n) begin
         trace.valid <= 1'b0;
         x_wb        <= '0;
      end else begin
         trace.valid <= retire.valid;
         x_wb        <= wb_d;
      end
   end

endmodule

// File: verilog/rvvi_bridge_pkg.sv
package rvvi_bridge_pkg;

   ////////////////////////////////////////
   // Widths and CSR slots
   ////////////////////////////////////////
   localparam int xlen    = 32;
   localparam int num_csr = 8;

   // Slot of each kept machine CSR in the CSR arrays
   localparam int csr_mstatus  = 0;
   localparam int csr_mie      = 1;
   localparam int csr_mtvec    = 2;
   localparam int csr_mscratch = 3;
   localparam int csr_mepc     = 4;
   localparam int csr_mcause   = 5;
   localparam int csr_mtval    = 6;
   localparam int csr_mip      = 7;

   // MSW, timer, external and the sixteen local lines
   localparam logic [31:0] irq_track_mask = 32'hffff_0888;

   ////////////////////////////////////////
   // Cause encodings
   ////////////////////////////////////////
   localparam logic [10:0] cause_nmi_load      = 11'd1024;
   localparam logic [10:0] cause_nmi_store     = 11'd1025;
   localparam logic [5:0]  exc_instr_bus_fault = 6'd48;
   localparam logic [2:0]  dbg_cause_haltreq   = 3'd3;

   // Interrupt cause read as a number or as an IRQ line index
   typedef union packed {
      logic [10:0] raw;
      struct packed {
         logic [5:0] upper;
         logic [4:0] idx;
      } irq;
   } intr_cause_u;

   typedef struct packed {
      logic       trap;
      logic       exception;
      logic       debug;
      logic [5:0] exception_cause;
      logic [2:0] debug_cause;
      logic [1:0] cause_type;
   } rvfi_trap_t;

   typedef struct packed {
      logic        intr;
      logic        exception;
      logic        interrupt;
      intr_cause_u cause;
   } rvfi_intr_t;

   // One retirement record from the formal trace port
   typedef struct packed {
      logic            valid;
      logic [63:0]     order;
      logic [31:0]     insn;
      rvfi_trap_t      trap;
      rvfi_intr_t      intr;
      logic [1:0]      mode;
      logic [1:0]      ixl;
      logic [xlen-1:0] pc_rdata;
      logic [xlen-1:0] pc_wdata;
      logic [4:0]      rd_addr;
      logic [xlen-1:0] rd_wdata;
      logic [2:0]      dbg;
      logic            dbg_mode;
      logic [1:0]      nmip;
   } rvfi_retire_t;

   typedef struct packed {
      logic [xlen-1:0] rdata;
      logic [xlen-1:0] wdata;
      logic [xlen-1:0] wmask;
   } csr_port_t;

   typedef struct packed {
      logic            valid;
      logic [63:0]     order;
      logic [31:0]     insn;
      logic            trap;
      rvfi_intr_t      intr;
      logic [1:0]      mode;
      logic [1:0]      ixl;
      logic [xlen-1:0] pc_rdata;
      logic [xlen-1:0] pc_wdata;
   } rvvi_trace_t;

   // Asynchronous net levels
   typedef struct packed {
      logic [31:0] irq;
      logic        nmi;
      logic [10:0] nmi_cause;
      logic        instr_bus_fault;
      logic        haltreq;
   } net_state_t;

   typedef enum logic [1:0] {
      NMI_IDLE,
      NMI_LOAD,
      NMI_STORE
   } nmi_state_e;

endpackage

// File: verilog/rvvi_bridge_top.sv
`timescale 1ns/1ps

module rvvi_bridge_top (
   input  logic                                        rvvi,
   input  logic                                        rst_n,
   input  rvvi_bridge_pkg::rvfi_retire_t               retire,
   input  rvvi_bridge_pkg::csr_port_t [rvvi_bridge_pkg::num_csr-1:0] csr,
   input  logic [31:0]                                 irq,
   output rvvi_bridge_pkg::rvvi_trace_t                trace,
   output logic [31:0]                                 x_wb,
   output logic [rvvi_bridge_pkg::xlen-1:0]            x_wdata,
   output logic [rvvi_bridge_pkg::num_csr-1:0][rvvi_bridge_pkg::xlen-1:0] csr_value,
   output logic [rvvi_bridge_pkg::num_csr-1:0]        csr_wb,
   output rvvi_bridge_pkg::net_state_t                 nets,
   output logic                                        resync
);
   import rvvi_bridge_pkg::*;

   retire_capture i_retire_capture (
      .rvvi    (rvvi),
      .rst_n   (rst_n),
      .retire  (retire),
      .trace   (trace),
      .x_wb    (x_wb),
      .x_wdata (x_wdata)
   );

   csr_merge i_csr_merge (
      .rvvi      (rvvi),
      .rst_n     (rst_n),
      .retire    (retire),
      .csr       (csr),
      .csr_value (csr_value),
      .csr_wb    (csr_wb)
   );

   // Registered mip drives the IRQ levels
   irq_tracker i_irq_tracker (
      .rvvi      (rvvi),
      .rst_n     (rst_n),
      .retire    (retire),
      .mip       (csr_value[csr_mip]),
      .irq       (irq),
      .irq_level (nets.irq)
   );

   async_event_tracker i_async_event_tracker (
      .rvvi            (rvvi),
      .rst_n           (rst_n),
      .retire          (retire),
      .nmi             (nets.nmi),
      .nmi_cause       (nets.nmi_cause),
      .instr_bus_fault (nets.instr_bus_fault),
      .haltreq         (nets.haltreq),
      .resync          (resync)
   );

endmodule
